// ==== source/l2_pkg.sv ====
package l2_pkg;

	// result vector width from the layer-2 engine
	localparam int L2_DATA_W = 128;

	// flat SRAM address, 256 entries per side
	localparam int L2_ADDR_W = 8;

	// row or column index into the feature map
	localparam int COORD_W = 8;

	typedef logic [L2_DATA_W-1:0] l2_vec_t;	// one layer-2 result vector
	typedef logic [COORD_W-1:0] coord_t;	// map row or column

	// buffer side select, 0 or 1
	typedef logic side_t;

	// write request from layer-2 engine, 144 bits
	typedef struct packed
	{
		coord_t row;	// map row of the result
		coord_t col;	// map column of the result
		l2_vec_t data;	// result vector
	} l2_wr_t;

	// read request from layer-3 engine, 16 bits
	typedef struct packed
	{
		coord_t row;	// map row to fetch
		coord_t col;	// map column to fetch
	} l2_rd_t;

endpackage

// ==== source/l2_result_sram.sv ====
`timescale 1ns/1ps

// behavioral stand-in for the dual-port SRAM macro
// port A only writes, port B only reads
module l2_result_sram
	import l2_pkg::*;
#(
	parameter type payload_t = l2_vec_t,	// word type stored per entry
	parameter int DEPTH = 1 << L2_ADDR_W	// number of words
)
(
	input  logic                 clk,
	input  logic                 wea,	// port A write strobe
	input  logic [L2_ADDR_W-1:0] addr_a,	// port A word address
	input  payload_t             din_a,	// port A write data
	input  logic                 oeb,	// port B read / output enable
	input  logic [L2_ADDR_W-1:0] addr_b,	// port B word address
	output payload_t             dout_b	// port B data, one cycle after oeb
);

	payload_t mem [DEPTH];	// storage array, powers up unknown like the macro
	payload_t rd_q;		// port B output latch
	logic     oe_q;		// oeb seen on last edge

	// port A write
	always_ff @(posedge clk)
	begin
		if (wea)
		begin
			mem[addr_a] <= din_a;
		end
	end

	// port B registered read
	always_ff @(posedge clk)
	begin
		oe_q <= oeb;
		if (oeb)
		begin
			rd_q <= mem[addr_b];	// only toggles the latch on a real read
		end
	end

	// output enable forces the bus to zero between reads
	always_comb
	begin
		if (oe_q)
		begin
			dout_b = rd_q;
		end
		else
		begin
			dout_b = '0;
		end
	end

endmodule

// ==== source/l2_result_one_side_mem.sv ====
`timescale 1ns/1ps

// one half of the ping-pong buffer
// row/col pairs are flattened to row*MAP_DIM+col before hitting the SRAM
module l2_result_one_side_mem
	import l2_pkg::*;
#(
	parameter int MAP_DIM = 14	// feature-map width, MAP_DIM*MAP_DIM must fit 256
)
(
	input  logic    clk,
	input  logic    save_en,	// store save_req this edge
	input  l2_wr_t  save_req,	// row, col and vector to store
	input  logic    read_en,	// fetch read_req this edge
	input  l2_rd_t  read_req,	// row and col to fetch
	output l2_vec_t read_data	// vector one cycle after read_en, else zero
);

	logic [L2_ADDR_W-1:0] save_addr;	// flat write address
	logic [L2_ADDR_W-1:0] read_addr;	// flat read address

	// row*MAP_DIM + col, wraps at the SRAM address width
	function automatic logic [L2_ADDR_W-1:0] map_addr(input coord_t row, input coord_t col);
		logic [COORD_W+3:0] row_x16;	// row << 4
		logic [COORD_W:0]   row_x2;	// row << 1
		int unsigned        lin;	// generic product for other widths
		logic [L2_ADDR_W-1:0] flat;
		row_x16 = {row, 4'b0000};
		row_x2 = {row, 1'b0};
		lin = row * MAP_DIM + col;
		if (MAP_DIM == 14)
		begin
			// 16r - 2r = 14r, no multiplier needed
			flat = row_x16[L2_ADDR_W-1:0] + col[L2_ADDR_W-1:0] - row_x2[L2_ADDR_W-1:0];
		end
		else
		begin
			flat = lin[L2_ADDR_W-1:0];
		end
		return flat;
	endfunction

	always_comb
	begin
		save_addr = map_addr(save_req.row, save_req.col);
		read_addr = map_addr(read_req.row, read_req.col);
	end

	// one macro per side, sized to the map
	l2_result_sram #(
		.payload_t (l2_vec_t),
		.DEPTH     (MAP_DIM * MAP_DIM)
	) u_sram (
		.clk    (clk),
		.wea    (save_en),		// port A is write only
		.addr_a (save_addr),
		.din_a  (save_req.data),
		.oeb    (read_en),		// port B is read only
		.addr_b (read_addr),
		.dout_b (read_data)
	);

endmodule

// ==== source/l2_side_ctrl.sv ====
`timescale 1ns/1ps

// ping-pong side controller
// layer-2 writes go to wr_side, layer-3 reads go to the other side
module l2_side_ctrl
	import l2_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr_en,		// write strobe from layer-2 engine
	input  logic       rd_en,		// read strobe from layer-3 engine
	input  logic       swap,		// frame done, flip sides
	output logic [1:0] side_wr_en,		// per-side write enable
	output logic [1:0] side_rd_en,		// per-side read enable
	input  l2_vec_t    side_rd_data0,	// returned vector from side 0
	input  l2_vec_t    side_rd_data1,	// returned vector from side 1
	output side_t      wr_side,		// side currently being filled
	output l2_vec_t    rd_data,		// selected read vector
	output logic       rd_valid		// rd_data holds a result
);

	// read in flight, one stage deep
	typedef struct packed
	{
		logic  vld;	// a read was issued last edge
		side_t side;	// which side it went to
	} rd_tag_t;

	side_t   cur_side;	// write side
	side_t   rd_side;	// read side, always the opposite one
	rd_tag_t tag_q;

	assign rd_side = ~cur_side;

	// write side flips after the swap edge
	// same-cycle write and read still use the old sides
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cur_side <= 1'b0;
		end
		else if (swap)
		begin
			cur_side <= ~cur_side;
		end
	end

	// remember where the read went so the data mux matches
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tag_q <= '0;
		end
		else
		begin
			tag_q.vld <= rd_en;
			tag_q.side <= rd_side;
		end
	end

	// enable decode
	always_comb
	begin
		side_wr_en[0] = wr_en & (cur_side == 1'b0);
		side_wr_en[1] = wr_en & (cur_side == 1'b1);
		side_rd_en[0] = rd_en & (rd_side == 1'b0);
		side_rd_en[1] = rd_en & (rd_side == 1'b1);
	end

	// return mux, zero when nothing is coming back
	always_comb
	begin
		if (!tag_q.vld)
		begin
			rd_data = '0;
		end
		else if (tag_q.side)
		begin
			rd_data = side_rd_data1;
		end
		else
		begin
			rd_data = side_rd_data0;
		end
	end

	assign rd_valid = tag_q.vld;	// fixed one-cycle latency
	assign wr_side = cur_side;

endmodule

// ==== source/l2_result_buffer.sv ====
`timescale 1ns/1ps

// layer-2 result buffer, ping-pong pair between layer-2 and layer-3 engines
// layer-2 fills wr_side while layer-3 reads the other side
module l2_result_buffer
	import l2_pkg::*;
#(
	parameter int MAP_DIM = 14	// feature-map width, shared by both sides
)
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    wr_en,		// store wr_req this edge
	input  l2_wr_t  wr_req,		// row, col, vector from layer-2
	input  logic    rd_en,		// fetch rd_req this edge
	input  l2_rd_t  rd_req,		// row, col from layer-3
	input  logic    swap,		// one-cycle pulse at end of a layer-2 frame
	output l2_vec_t rd_data,	// vector, one cycle after rd_en
	output logic    rd_valid,	// qualifies rd_data
	output side_t   wr_side		// side the producer is filling
);

	logic [1:0] side_wr_en;		// write enables, one per side
	logic [1:0] side_rd_en;		// read enables, one per side
	l2_vec_t    side_rd_data0;	// side 0 read return
	l2_vec_t    side_rd_data1;	// side 1 read return

	// side select, enable decode and return mux
	l2_side_ctrl u_side_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.wr_en         (wr_en),
		.rd_en         (rd_en),
		.swap          (swap),
		.side_wr_en    (side_wr_en),
		.side_rd_en    (side_rd_en),
		.side_rd_data0 (side_rd_data0),
		.side_rd_data1 (side_rd_data1),
		.wr_side       (wr_side),
		.rd_data       (rd_data),
		.rd_valid      (rd_valid)
	);

	// both sides see the same request buses
	// only the enables tell them apart
	l2_result_one_side_mem #(
		.MAP_DIM (MAP_DIM)
	) side0 (
		.clk       (clk),
		.save_en   (side_wr_en[0]),
		.save_req  (wr_req),
		.read_en   (side_rd_en[0]),
		.read_req  (rd_req),
		.read_data (side_rd_data0)
	);

	l2_result_one_side_mem #(
		.MAP_DIM (MAP_DIM)
	) side1 (
		.clk       (clk),
		.save_en   (side_wr_en[1]),
		.save_req  (wr_req),
		.read_en   (side_rd_en[1]),
		.read_req  (rd_req),
		.read_data (side_rd_data1)
	);

endmodule

// ==== tb/l2_result_buffer_sva.sv ====
`timescale 1ns/1ps

// boundary timing rules of the layer-2 result buffer
module l2_result_buffer_sva
	import l2_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input logic    rd_en,	// read strobe into the buffer
	input logic    rd_valid,	// read return qualifier
	input l2_vec_t rd_data,	// returned vector
	input side_t   wr_side	// side being filled
);

	// every read returns exactly one cycle later
	read_latency: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |=> rd_valid)
		else $error("rd_valid missing one cycle after rd_en");

	// bus parks at zero between results
	idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!rd_valid |-> (rd_data == '0))
		else $error("rd_data not zero while rd_valid is low");

	// first edge out of reset still shows the reset state
	reset_state: assert property (@(posedge clk)
		$rose(rst_n) |-> (!rd_valid && (wr_side == 1'b0)))
		else $error("rd_valid or wr_side not cleared by reset");

endmodule

bind l2_result_buffer l2_result_buffer_sva u_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.rd_en    (rd_en),
	.rd_valid (rd_valid),
	.rd_data  (rd_data),
	.wr_side  (wr_side)
);

// ==== tb/tb_l2_result_buffer.sv ====
`timescale 1ns/1ps

// testbench for the layer-2 ping-pong result buffer
// operations and expected vectors come from tb/l2_stim.txt
module tb_l2_result_buffer
	import l2_pkg::*;
();

	localparam int MAP_DIM = 14;	// same map width as the DUT
	localparam int RST_CYCLES = 4;
	localparam int CLK_HALF = 4;	// 8 ns period

	// one parsed stim line
	typedef struct packed
	{
		logic [63:0] op;	// opcode text right aligned
		coord_t      row;
		coord_t      col;
		l2_vec_t     data;	// write vector or frame tag
		l2_vec_t     expv;	// read vector or frame tag
	} stim_t;

	// one read waiting for its result
	typedef struct packed
	{
		coord_t  row;
		coord_t  col;
		l2_vec_t val;	// expected vector
		int      due;	// cycle where rd_valid has to show
	} rd_exp_t;

	logic    clk;
	logic    rst_n;
	logic    wr_en;
	l2_wr_t  wr_req;
	logic    rd_en;
	l2_rd_t  rd_req;
	logic    swap;
	l2_vec_t rd_data;
	logic    rd_valid;
	side_t   wr_side;

	stim_t   stim_q[$];	// whole stim file
	rd_exp_t exp_q[$];	// reads in flight
	side_t   exp_side;	// expected write side
	int      cyc = 0;	// rising edges so far
	int      limit = 1000;	// watchdog limit set again from the stim length
	int      data_errs = 0;
	int      proto_errs = 0;

	l2_result_buffer #(
		.MAP_DIM (MAP_DIM)
	) UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_req   (wr_req),
		.rd_en    (rd_en),
		.rd_req   (rd_req),
		.swap     (swap),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.wr_side  (wr_side)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#CLK_HALF clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
	end

	// write side starts at 0 and flips on every swap pulse
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			exp_side <= 1'b0;
		end
		else if (swap)
		begin
			exp_side <= ~exp_side;
		end
	end

	// frame pattern built from the tag and both coordinates
	function automatic l2_vec_t frame_vec(input l2_vec_t tag, input int row, input int col);
		logic [15:0] pos;
		pos = {row[7:0], col[7:0]};
		return {tag[31:0], pos, ~pos, tag[31:0] ^ {pos, pos},
			16'(row * 37 + 1), 16'(col * 53 + 7)};
	endfunction

	// coordinate on the far side of the map
	function automatic int mirror_coord(input int v);
		return MAP_DIM - 1 - v;
	endfunction

	function automatic int op_cycles(input logic [63:0] op);
		if (op == "fill" || op == "check" || op == "wrcheck")
		begin
			return MAP_DIM * MAP_DIM;	// one position per cycle
		end
		return 1;
	endfunction

	task automatic load_stim(output logic ok);
		int            fd;
		int            n;
		int            row;
		int            col;
		logic [1023:0] line;
		logic [63:0]   op;
		l2_vec_t       data;
		l2_vec_t       expv;
		stim_t         ent;
		ok = 1'b0;
		fd = $fopen("tb/l2_stim.txt", "r");
		assert (fd != 0) else
		begin
			proto_errs++;
			$display("could not open stim file tb/l2_stim.txt");
		end
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = '0;
				op = '0;
				n = $fgets(line, fd);
				if (n > 0)
				begin
					n = $sscanf(line, "%s %d %d %h %h", op, row, col, data, expv);
				end
				if (n == 5)
				begin
					ent.op = op;
					ent.row = coord_t'(row);
					ent.col = coord_t'(col);
					ent.data = data;
					ent.expv = expv;
					stim_q.push_back(ent);
				end
				else if (n > 0 && op != "#")	// header lines start with #
				begin
					proto_errs++;
					$display("stim line could not be read: %0s", line);
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// one clock of stimulus
	task automatic drive_cycle(input logic we, input logic re, input logic sw,
		input int wrow, input int wcol, input l2_vec_t wdata,
		input int rrow, input int rcol, input l2_vec_t rexp);
		rd_exp_t ent;
		@(posedge clk);
		wr_en <= we;
		rd_en <= re;
		swap <= sw;
		wr_req.row <= coord_t'(wrow);	// write and read buses carry their own position
		wr_req.col <= coord_t'(wcol);
		wr_req.data <= wdata;
		rd_req.row <= coord_t'(rrow);
		rd_req.col <= coord_t'(rcol);
		if (re)
		begin
			ent.row = coord_t'(rrow);
			ent.col = coord_t'(rcol);
			ent.val = rexp;
			ent.due = cyc + 2;	// DUT samples on the next edge and data shows after it
			exp_q.push_back(ent);
		end
	endtask

	task automatic run_op(input stim_t s);
		if (s.op == "write")
		begin
			drive_cycle(1'b1, 1'b0, 1'b0, s.row, s.col, s.data,
				mirror_coord(s.row), mirror_coord(s.col), '0);
		end
		else if (s.op == "read")
		begin
			drive_cycle(1'b0, 1'b1, 1'b0, mirror_coord(s.row), mirror_coord(s.col), '0,
				s.row, s.col, s.expv);
		end
		else if (s.op == "swap")
		begin
			drive_cycle(1'b0, 1'b0, 1'b1, 0, 0, '0, 0, 0, '0);
		end
		else if (s.op == "idle")
		begin
			drive_cycle(1'b0, 1'b0, 1'b0, 0, 0, '0, 0, 0, '0);
		end
		else if (s.op == "wrswap")
		begin
			drive_cycle(1'b1, 1'b1, 1'b1, s.row, s.col, s.data, s.row, s.col, s.expv);
		end
		else if (op_cycles(s.op) > 1)
		begin
			// whole frame with the data tag written and the expv tag read back
			// reads walk the frame from the opposite corner
			for (int r = 0; r < MAP_DIM; r++)
			begin
				for (int c = 0; c < MAP_DIM; c++)
				begin
					drive_cycle(s.op != "check", s.op != "fill", 1'b0,
						r, c, frame_vec(s.data, r, c),
						mirror_coord(r), mirror_coord(c),
						frame_vec(s.expv, mirror_coord(r), mirror_coord(c)));
				end
			end
		end
		else
		begin
			proto_errs++;
			$display("unknown opcode %0s in stim file", s.op);
		end
	endtask

	task automatic finish_run(input logic timed_out);
		$display("errors: %0d total, %0d data, %0d protocol",
			data_errs + proto_errs, data_errs, proto_errs);
		if (data_errs == 0 && proto_errs == 0 && !timed_out)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	endtask

	// outputs are checked half a cycle after the edge
	always @(negedge clk)
	begin : monitor
		rd_exp_t head;
		if (rst_n)
		begin
			assert (wr_side === exp_side) else
			begin
				data_errs++;
				$display("FAILED %0t: wr_side is %0d, expected %0d", $time, wr_side, exp_side);
			end
			assert (!(rd_valid && exp_q.size() == 0)) else
			begin
				proto_errs++;
				$display("rd_valid went high at %0t with no read outstanding", $time);
			end
			if (rd_valid && exp_q.size() != 0)
			begin
				head = exp_q.pop_front();
				assert (cyc == head.due) else
				begin
					proto_errs++;
					$display("read of (%0d,%0d) came back at cycle %0d instead of %0d",
						head.row, head.col, cyc, head.due);
				end
				assert (rd_data === head.val) else
				begin
					data_errs++;
					$display("FAILED %0t: read (%0d,%0d) returned %h, expected %h",
						$time, head.row, head.col, rd_data, head.val);
				end
			end
			else if (!rd_valid)
			begin
				assert (rd_data === '0) else
				begin
					data_errs++;
					$display("FAILED %0t: rd_data %h while rd_valid is low", $time, rd_data);
				end
				assert (exp_q.size() == 0 || exp_q[0].due > cyc) else
				begin
					proto_errs++;
					$display("rd_valid never came for the read of (%0d,%0d), due at cycle %0d",
						exp_q[0].row, exp_q[0].col, exp_q[0].due);
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial
	begin : watchdog
		@(posedge clk);
		while (cyc < limit)
		begin
			@(posedge clk);
		end
		proto_errs++;
		$display("run stopped by timeout after %0d cycles, %0d reads outstanding",
			cyc, exp_q.size());
		finish_run(1'b1);
	end

	initial
	begin : main
		logic ok;
		int   total;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_req = '0;
		rd_en = 1'b0;
		rd_req = '0;
		swap = 1'b0;
		load_stim(ok);
		if (!ok)
		begin
			finish_run(1'b0);
		end
		else
		begin
			total = RST_CYCLES + 2;	// reset plus drain
			foreach (stim_q[i])
			begin
				total += op_cycles(stim_q[i].op);
			end
			limit = 2 * total + 50;
			repeat (RST_CYCLES) @(posedge clk);
			rst_n <= 1'b1;
			foreach (stim_q[i])
			begin
				run_op(stim_q[i]);
			end
			drive_cycle(1'b0, 1'b0, 1'b0, 0, 0, '0, 0, 0, '0);	// drop the last strobes
			while (exp_q.size() != 0)
			begin
				@(posedge clk);
			end
			@(negedge clk);	// one more idle cycle through the monitor
			finish_run(1'b0);
		end
	end

endmodule

// ==== tb/l2_stim.txt ====
# columns: op row col data expected, data and expected in hex
# fill, check and wrcheck run a whole frame, data is the tag written, expected the tag read
idle    0  0  0 0
idle    0  0  0 0
fill    0  0  a1 0
idle    0  0  0 0
swap    0  0  0 0
idle    0  0  0 0
check   0  0  0 a1
idle    0  0  0 0
wrcheck 0  0  b2 a1
idle    0  0  0 0
swap    0  0  0 0
check   0  0  0 b2
idle    0  0  0 0
write   3  3  33333333000000000000000000000303 0
write   1  1  11111111000000000000000000000101 0
write   2  2  22222222000000000000000000000202 0
write   0  0  c0c0c0c0ffffffffffffffff00000000 0
write   13 13 dddddddd123456789abcdef00000d0d0 0
write   0  13 0d0d0d0d00000000deadbeef00000d00 0
write   13 0  d00d0d00cafef00d00000000000000d0 0
idle    0  0  0 0
swap    0  0  0 0
read    1  1  0 11111111000000000000000000000101
read    2  2  0 22222222000000000000000000000202
read    3  3  0 33333333000000000000000000000303
read    0  0  0 c0c0c0c0ffffffffffffffff00000000
read    13 13 0 dddddddd123456789abcdef00000d0d0
read    0  13 0 0d0d0d0d00000000deadbeef00000d00
read    13 0  0 d00d0d00cafef00d00000000000000d0
idle    0  0  0 0
read    13 13 0 dddddddd123456789abcdef00000d0d0
idle    0  0  0 0
write   1  1  aaaaaaaa55555555aaaaaaaa55555555 0
read    1  1  0 11111111000000000000000000000101
write   13 13 eeeeeeee0000000011111111eeeeeeee 0
read    13 13 0 dddddddd123456789abcdef00000d0d0
read    3  3  0 33333333000000000000000000000303
wrswap  3  3  cccccccc33333333cccccccc33333333 33333333000000000000000000000303
read    3  3  0 cccccccc33333333cccccccc33333333
read    1  1  0 aaaaaaaa55555555aaaaaaaa55555555
read    13 13 0 eeeeeeee0000000011111111eeeeeeee
idle    0  0  0 0
idle    0  0  0 0
swap    0  0  0 0
read    2  2  0 22222222000000000000000000000202
read    0  13 0 0d0d0d0d00000000deadbeef00000d00
idle    0  0  0 0
swap    0  0  0 0
swap    0  0  0 0
read    13 0  0 d00d0d00cafef00d00000000000000d0
read    0  0  0 c0c0c0c0ffffffffffffffff00000000
idle    0  0  0 0
idle    0  0  0 0

// ==== src.f ====
source/l2_pkg.sv
source/l2_result_sram.sv
source/l2_result_one_side_mem.sv
source/l2_side_ctrl.sv
source/l2_result_buffer.sv
tb/l2_result_buffer_sva.sv
tb/tb_l2_result_buffer.sv
